/* hw/uart_pkg.sv */
// uart_pkg: register offsets, response codes, fifo and divisor constants, write fsm codes, write-data union
package uart_pkg;

	// axi-lite address and data width
	localparam int ADDR_W = 32;

	// register offsets, decoded on address bits [3:0]
	localparam logic [3:0] REG_TXDATA  = 4'h0;
	localparam logic [3:0] REG_DIVISOR = 4'h4;

	// bresp codes
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// transmit fifo
	localparam int TX_FIFO_DEPTH = 8;
	localparam int FIFO_PTR_W    = $clog2(TX_FIFO_DEPTH);

	// bit period in clock cycles
	localparam int               DIV_W       = 16;
	localparam logic [DIV_W-1:0] DEFAULT_DIV = 16'd16;
	localparam logic [DIV_W-1:0] MIN_DIV     = 16'd2;

	// start + 8 data + stop
	localparam int FRAME_BITS = 10;

	// write channel fsm codes
	localparam int                    WR_STATE_W   = 3;
	localparam logic [WR_STATE_W-1:0] WR_IDLE      = 3'd0;
	localparam logic [WR_STATE_W-1:0] WR_WAIT_AW   = 3'd1;
	localparam logic [WR_STATE_W-1:0] WR_SHAKED_AW = 3'd2;
	localparam logic [WR_STATE_W-1:0] WR_WAIT_W    = 3'd3;
	localparam logic [WR_STATE_W-1:0] WR_SHAKED_W  = 3'd4;
	localparam logic [WR_STATE_W-1:0] WR_WAIT_FIFO = 3'd5;
	localparam logic [WR_STATE_W-1:0] WR_WAIT_B    = 3'd6;
	localparam logic [WR_STATE_W-1:0] WR_SHAKED_B  = 3'd7;

	// write data word, seen as a tx byte or as a divisor
	typedef union packed {
		struct packed {
			logic [ADDR_W-9:0] rsvd;
			logic [7:0]        data;
		} tx;
		struct packed {
			logic [ADDR_W-DIV_W-1:0] rsvd;
			logic [DIV_W-1:0]        divisor;
		} div;
	} uart_wdata_u;

endpackage

/* hw/uart_tx_if.sv */
// uart_tx_if: queue strobe, byte, full flag and divisor between bus slave, fifo and serializer
`timescale 1ns/1ns

interface uart_tx_if;

	// one-cycle strobe, byte is queued on that edge
	logic push;
	logic [7:0] push_data;

	// registered in the fifo
	logic full;

	// cycles per bit, already clamped by the slave
	logic [uart_pkg::DIV_W-1:0] baud_div;

	// bus slave side
	modport ctrl (
		output push,
		output push_data,
		output baud_div,
		input  full
	);

	// fifo write side
	modport fifo (
		input  push,
		input  push_data,
		output full
	);

	// serializer only needs the bit period
	modport ser (
		input  baud_div
	);

endinterface

/* hw/uart_axil_slave.sv */
// uart_axil_slave: axi-lite write fsm, address capture, register decode, divisor register, bresp
`timescale 1ns/1ns

module uart_axil_slave (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [uart_pkg::ADDR_W-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [uart_pkg::ADDR_W-1:0] wdata,
	input  logic [3:0]                  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	uart_tx_if.ctrl                     tx
);

	logic [uart_pkg::WR_STATE_W-1:0] state_w;
	logic [uart_pkg::WR_STATE_W-1:0] next_w;

	// decoded offset, latched at the aw transfer
	logic [3:0] addr_r;

	uart_pkg::uart_wdata_u wdata_u;

	logic aw_fire;
	logic w_fire;
	logic tx_sel;
	logic div_sel;
	logic tx_req;
	logic div_req;
	logic tx_stall;
	logic push_go;

	logic [uart_pkg::DIV_W-1:0] div_clamped;

	logic                       push_r;
	logic [7:0]                 data_r;
	logic [uart_pkg::DIV_W-1:0] div_r;
	logic [1:0]                 bresp_r;

	assign wdata_u = wdata;

	assign aw_fire = awready && awvalid;
	assign w_fire  = wready && wvalid;

	// register decode
	assign tx_sel  = (addr_r == uart_pkg::REG_TXDATA);
	assign div_sel = (addr_r == uart_pkg::REG_DIVISOR);
	assign tx_req  = tx_sel && wstrb[0];
	assign div_req = div_sel && (wstrb[1:0] == 2'b11);

	// tx byte with no room, hold off the response
	assign tx_stall = tx_req && tx.full;

	// push now, or once the fifo drains while waiting
	assign push_go = !tx.full &&
		((w_fire && tx_req) || (state_w == uart_pkg::WR_WAIT_FIFO));

	// too-small divisors are raised to the floor
	assign div_clamped = (wdata_u.div.divisor < uart_pkg::MIN_DIV) ?
		uart_pkg::MIN_DIV : wdata_u.div.divisor;

	always_ff @(posedge clk) begin
		if (rst) begin
			state_w <= uart_pkg::WR_IDLE;
		end else begin
			state_w <= next_w;
		end
	end

	// one write in flight, aw then w then b
	always_comb begin
		next_w = state_w;
		case (state_w)
			uart_pkg::WR_IDLE: begin
				// awready comes up one cycle after reset
				if (!awready) begin
					next_w = uart_pkg::WR_IDLE;
				end else if (aw_fire) begin
					next_w = uart_pkg::WR_SHAKED_AW;
				end else begin
					next_w = uart_pkg::WR_WAIT_AW;
				end
			end
			uart_pkg::WR_WAIT_AW: begin
				if (aw_fire) begin
					next_w = uart_pkg::WR_SHAKED_AW;
				end
			end
			uart_pkg::WR_SHAKED_AW,
			uart_pkg::WR_WAIT_W: begin
				if (!w_fire) begin
					next_w = uart_pkg::WR_WAIT_W;
				end else if (tx_stall) begin
					next_w = uart_pkg::WR_WAIT_FIFO;
				end else begin
					next_w = uart_pkg::WR_SHAKED_W;
				end
			end
			uart_pkg::WR_WAIT_FIFO: begin
				if (!tx.full) begin
					next_w = uart_pkg::WR_SHAKED_W;
				end
			end
			uart_pkg::WR_SHAKED_W,
			uart_pkg::WR_WAIT_B: begin
				if (bready) begin
					next_w = uart_pkg::WR_SHAKED_B;
				end else begin
					next_w = uart_pkg::WR_WAIT_B;
				end
			end
			uart_pkg::WR_SHAKED_B: begin
				// awready already high here
				if (aw_fire) begin
					next_w = uart_pkg::WR_SHAKED_AW;
				end else begin
					next_w = uart_pkg::WR_WAIT_AW;
				end
			end
			default: begin
				next_w = uart_pkg::WR_IDLE;
			end
		endcase
	end

	// handshake outputs registered from next state
	always_ff @(posedge clk) begin
		if (rst) begin
			awready <= 1'b0;
			wready  <= 1'b0;
			bvalid  <= 1'b0;
		end else begin
			awready <= (next_w == uart_pkg::WR_IDLE) || (next_w == uart_pkg::WR_WAIT_AW) ||
				(next_w == uart_pkg::WR_SHAKED_B);
			wready  <= (next_w == uart_pkg::WR_SHAKED_AW) || (next_w == uart_pkg::WR_WAIT_W);
			bvalid  <= (next_w == uart_pkg::WR_SHAKED_W) || (next_w == uart_pkg::WR_WAIT_B);
		end
	end

	// offset only, upper address bits ignored
	always_ff @(posedge clk) begin
		if (aw_fire) begin
			addr_r <= awaddr[3:0];
		end
	end

	// byte kept for a delayed push
	always_ff @(posedge clk) begin
		if (w_fire) begin
			data_r <= wdata_u.tx.data;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			push_r  <= 1'b0;
			div_r   <= uart_pkg::DEFAULT_DIV;
			bresp_r <= uart_pkg::RESP_OKAY;
		end else begin
			push_r <= push_go;
			if (w_fire) begin
				// unmapped offsets error, mapped ones answer okay
				bresp_r <= (tx_sel || div_sel) ? uart_pkg::RESP_OKAY : uart_pkg::RESP_SLVERR;
				if (div_req) begin
					div_r <= div_clamped;
				end
			end
		end
	end

	assign bresp = bresp_r;

	assign tx.push      = push_r;
	assign tx.push_data = data_r;
	assign tx.baud_div  = div_r;

endmodule

/* hw/uart_tx_fifo.sv */
// uart_tx_fifo: circular byte buffer with registered full and empty flags
`timescale 1ns/1ns

module uart_tx_fifo (
	input  logic       clk,
	input  logic       rst,
	uart_tx_if.fifo    tx,
	input  logic       pop_req,
	output logic       empty,
	output logic [7:0] head_data
);

	logic [7:0] mem [uart_pkg::TX_FIFO_DEPTH];

	logic [uart_pkg::FIFO_PTR_W-1:0] wr_ptr;
	logic [uart_pkg::FIFO_PTR_W-1:0] rd_ptr;

	// holds 0 .. depth
	logic [uart_pkg::FIFO_PTR_W:0] count;
	logic [uart_pkg::FIFO_PTR_W:0] count_next;

	logic do_push;
	logic do_pop;

	logic full_r;

	// guard against overrun and underrun
	assign do_push = tx.push && !full_r;
	assign do_pop  = pop_req && !empty;

	always_comb begin
		count_next = count;
		if (do_push && !do_pop) begin
			count_next = count + 1'b1;
		end else if (do_pop && !do_push) begin
			count_next = count - 1'b1;
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= tx.push_data;
		end
	end

	// pointers wrap naturally, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			full_r <= 1'b0;
			empty  <= 1'b1;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			count  <= count_next;
			full_r <= (count_next == uart_pkg::TX_FIFO_DEPTH);
			empty  <= (count_next == '0);
		end
	end

	// oldest byte, valid whenever empty is low
	assign head_data = mem[rd_ptr];

	assign tx.full = full_r;

endmodule

/* hw/uart_tx_serializer.sv */
// uart_tx_serializer: bit-period counter, bit index and 8n1 shift frame driving txd
`timescale 1ns/1ns

module uart_tx_serializer (
	input  logic       clk,
	input  logic       rst,
	uart_tx_if.ser     tx,
	input  logic       empty,
	input  logic [7:0] head_data,
	output logic       pop_req,
	output logic       txd
);

	logic busy;

	// divisor frozen for the whole frame
	logic [uart_pkg::DIV_W-1:0] div_r;
	logic [uart_pkg::DIV_W-1:0] cnt;

	// 0 = start, 1..8 = data, 9 = stop
	logic [3:0] bit_idx;

	// lsb is on the line, ones shift in from the top
	logic [uart_pkg::FRAME_BITS-1:0] frame;

	logic bit_end;
	logic frame_end;

	assign bit_end   = (cnt == '0);
	assign frame_end = busy && bit_end && (bit_idx == 4'(uart_pkg::FRAME_BITS - 1));

	// fetch when idle or as the stop bit ends, so frames run back to back
	assign pop_req = !empty && (!busy || frame_end);

	assign txd = frame[0];

	always_ff @(posedge clk) begin
		if (rst) begin
			busy    <= 1'b0;
			cnt     <= '0;
			bit_idx <= '0;
			// line idles high
			frame   <= '1;
		end else if (pop_req) begin
			// head byte taken on the pop edge, start bit goes out next cycle
			busy    <= 1'b1;
			frame   <= {1'b1, head_data, 1'b0};
			cnt     <= tx.baud_div - 1'b1;
			bit_idx <= '0;
		end else if (frame_end) begin
			// stop bit done and nothing waiting
			busy <= 1'b0;
		end else if (busy) begin
			if (bit_end) begin
				frame   <= {1'b1, frame[uart_pkg::FRAME_BITS-1:1]};
				cnt     <= div_r - 1'b1;
				bit_idx <= bit_idx + 1'b1;
			end else begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	// sampled once per frame at the start bit
	always_ff @(posedge clk) begin
		if (pop_req) begin
			div_r <= tx.baud_div;
		end
	end

endmodule

/* hw/uart_top.sv */
// uart_top: axi-lite write slave, transmit fifo and serializer wired to the txd line
`timescale 1ns/1ns

module uart_top (
	input  logic                        clk,
	input  logic                        rst,
	input  logic [uart_pkg::ADDR_W-1:0] awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [uart_pkg::ADDR_W-1:0] wdata,
	input  logic [3:0]                  wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output logic [1:0]                  bresp,
	output logic                        bvalid,
	input  logic                        bready,
	output logic                        txd
);

	// slave to fifo and serializer
	uart_tx_if tx_bus ();

	// fifo to serializer
	logic       pop_req;
	logic       fifo_empty;
	logic [7:0] head_data;

	uart_axil_slave u_slave (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.tx      (tx_bus.ctrl)
	);

	uart_tx_fifo u_fifo (
		.clk       (clk),
		.rst       (rst),
		.tx        (tx_bus.fifo),
		.pop_req   (pop_req),
		.empty     (fifo_empty),
		.head_data (head_data)
	);

	uart_tx_serializer u_ser (
		.clk       (clk),
		.rst       (rst),
		.tx        (tx_bus.ser),
		.empty     (fifo_empty),
		.head_data (head_data),
		.pop_req   (pop_req),
		.txd       (txd)
	);

endmodule

/* verif/uart_axil_assertions.sv */
// uart_axil_assertions: axi-lite write channel protocol properties for the bus slave
`timescale 1ns/1ns

module uart_axil_assertions (
	input logic       clk,
	input logic       rst,
	input logic       awvalid,
	input logic       awready,
	input logic       wready,
	input logic [1:0] bresp,
	input logic       bvalid,
	input logic       bready
);

	// failures seen so far, summed into the testbench result
	int fail_count = 0;

	// response held until the master takes it
	b_held_a: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else begin
		$error("bvalid dropped or bresp changed before bready");
		fail_count = fail_count + 1;
	end

	// only one write in flight
	aw_b_excl_a: assert property (@(posedge clk) disable iff (rst)
		!(awready && bvalid))
	else begin
		$error("awready and bvalid high together");
		fail_count = fail_count + 1;
	end

	// data phase opens only after an address transfer
	w_after_aw_a: assert property (@(posedge clk) disable iff (rst)
		$rose(wready) |-> $past(awvalid && awready))
	else begin
		$error("wready rose without a preceding aw transfer");
		fail_count = fail_count + 1;
	end

endmodule

/* verif/tb_uart_top.sv */
// tb_uart_top: stimulus table, axi-lite write driver, txd monitor, lcg, watchdog and summary
`timescale 1ns/1ns

module tb_uart_top;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
		logic [3:0]  strb;
		logic [1:0]  resp;
		logic        has_byte;
		logic [7:0]  byte_val;
	} stim_t;

	logic        clk;
	logic        rst;
	logic [31:0] awaddr;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wvalid;
	logic        wready;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic        txd;

	stim_t       stim_q[$];
	logic [7:0]  exp_q[$];
	int          errors;
	int          cycles;
	int          cycle_limit;
	int          cur_div;
	logic [31:0] rng_state;
	logic        in_frame;

	uart_top dut (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.txd     (txd)
	);

	bind uart_axil_slave uart_axil_assertions u_axil_chk (
		.clk     (clk),
		.rst     (rst),
		.awvalid (awvalid),
		.awready (awready),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready)
	);

	always #10 clk = ~clk;

	// watchdog with a limit set at time zero from the table
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			report_counts();
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state;
	endfunction

	// junk in the reserved bits that the slave must ignore
	function automatic logic [31:0] byte_word(input logic [7:0] b);
		uart_pkg::uart_wdata_u w;
		w.tx.rsvd = 24'h5a5a5a;
		w.tx.data = b;
		return w;
	endfunction

	function automatic logic [31:0] div_word(input logic [15:0] d);
		uart_pkg::uart_wdata_u w;
		w.div.rsvd    = 16'hc3c3;
		w.div.divisor = d;
		return w;
	endfunction

	// bit period after a write with low values raised to the floor
	function automatic int expected_div(input stim_t e, input int old);
		uart_pkg::uart_wdata_u w;
		w = e.data;
		if (e.addr == 32'(uart_pkg::REG_DIVISOR) && e.strb[1:0] == 2'b11) begin
			if (w.div.divisor < uart_pkg::MIN_DIV) begin
				return int'(uart_pkg::MIN_DIV);
			end
			return int'(w.div.divisor);
		end
		return old;
	endfunction

	task automatic add_entry(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s,
		input logic [1:0] r, input logic hb, input logic [7:0] b);
		stim_t e;
		e.addr     = a;
		e.data     = d;
		e.strb     = s;
		e.resp     = r;
		e.has_byte = hb;
		e.byte_val = b;
		stim_q.push_back(e);
	endtask

	task automatic build_table();
		logic [7:0] b;
		int         i;
		// default bit period
		add_entry(32'h0, byte_word(8'h55), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, 8'h55);
		add_entry(32'h0, byte_word(8'ha3), 4'b1111, uart_pkg::RESP_OKAY, 1'b1, 8'ha3);
		add_entry(32'h0, byte_word(8'h0f), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, 8'h0f);
		// 4 cycles per bit
		add_entry(32'h4, div_word(16'd4), 4'b0011, uart_pkg::RESP_OKAY, 1'b0, 8'h00);
		add_entry(32'h0, byte_word(8'h81), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, 8'h81);
		add_entry(32'h0, byte_word(8'h3c), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, 8'h3c);
		// 1 gets clamped to the minimum
		add_entry(32'h4, div_word(16'd1), 4'b1111, uart_pkg::RESP_OKAY, 1'b0, 8'h00);
		// strobe 1 clear so the period stays at the minimum
		add_entry(32'h4, div_word(16'd9), 4'b0001, uart_pkg::RESP_OKAY, 1'b0, 8'h00);
		add_entry(32'h0, byte_word(8'he7), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, 8'he7);
		add_entry(32'h0, byte_word(8'h12), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, 8'h12);
		// unmapped offset and a byte write with strobe 0 clear
		add_entry(32'h8, byte_word(8'h99), 4'b1111, uart_pkg::RESP_SLVERR, 1'b0, 8'h00);
		add_entry(32'h0, byte_word(8'h66), 4'b1110, uart_pkg::RESP_OKAY, 1'b0, 8'h00);
		// slow line again so the burst fills the fifo
		add_entry(32'h4, div_word(16'd16), 4'b0011, uart_pkg::RESP_OKAY, 1'b0, 8'h00);
		for (i = 0; i < 12; i++) begin
			b = 8'(lcg_next() >> 16);
			add_entry(32'h0, byte_word(b), 4'b0001, uart_pkg::RESP_OKAY, 1'b1, b);
		end
	endtask

	// runs from 1 ns after one rising edge to 1 ns after a later one
	// ready and valid sampled at the falling edge
	task automatic axil_write(input stim_t e, input int hold, output logic [1:0] resp);
		awaddr  = e.addr;
		awvalid = 1'b1;
		wdata   = e.data;
		wstrb   = e.strb;
		wvalid  = 1'b1;
		@(negedge clk);
		while (!awready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		awvalid = 1'b0;
		@(negedge clk);
		while (!wready) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		wvalid = 1'b0;
		// response back-pressure
		repeat (hold) begin
			@(posedge clk);
			#1;
		end
		bready = 1'b1;
		@(negedge clk);
		while (!bvalid) begin
			@(negedge clk);
		end
		resp = bresp;
		@(posedge clk);
		#1;
		bready = 1'b0;
	endtask

	// all queued bytes decoded and no frame on the line
	task automatic wait_line_idle();
		while (exp_q.size() != 0 || in_frame) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	task automatic report_counts();
		$display("summary: %0d check errors, %0d assertion failures",
			errors, dut.u_slave.u_axil_chk.fail_count);
	endtask

	// serial line monitor sampling mid-bit on falling clock edges
	initial begin : txd_monitor
		logic [7:0] rx;
		logic [7:0] want;
		int         div;
		int         i;
		in_frame = 1'b0;
		@(negedge rst);
		forever begin
			@(negedge txd);
			in_frame = 1'b1;
			div = cur_div;
			repeat (div / 2) @(negedge clk);
			if (txd !== 1'b0) begin
				errors++;
				$display("FAIL t=%0t: start bit not low at mid-bit", $time);
			end
			// lsb first
			for (i = 0; i < 8; i++) begin
				repeat (div) @(negedge clk);
				rx[i] = txd;
			end
			repeat (div) @(negedge clk);
			if (txd !== 1'b1) begin
				errors++;
				$display("FAIL t=%0t: stop bit not high for byte 0x%02h", $time, rx);
			end
			if (exp_q.size() == 0) begin
				errors++;
				$display("extra byte 0x%02h appeared on txd with no write queuing it", rx);
			end else begin
				want = exp_q.pop_front();
				if (rx !== want) begin
					errors++;
					$display("FAIL t=%0t: txd byte 0x%02h, expected 0x%02h", $time, rx, want);
				end
			end
			in_frame = 1'b0;
		end
	end

	initial begin
		stim_t      ent;
		logic [1:0] resp;
		int         hold;
		int         frames;
		int         max_div;
		int         div;
		int         k;
		logic       exp_awready;
		clk       = 1'b0;
		rst       = 1'b1;
		awaddr    = '0;
		awvalid   = 1'b0;
		wdata     = '0;
		wstrb     = '0;
		wvalid    = 1'b0;
		bready    = 1'b0;
		errors    = 0;
		cycles    = 0;
		rng_state = 32'd76613;
		cur_div   = int'(uart_pkg::DEFAULT_DIV);
		build_table();
		// frames x bits x slowest period plus margin
		frames  = 0;
		div     = cur_div;
		max_div = cur_div;
		foreach (stim_q[i]) begin
			if (stim_q[i].has_byte) begin
				frames++;
			end
			div = expected_div(stim_q[i], div);
			if (div > max_div) begin
				max_div = div;
			end
		end
		cycle_limit = frames * uart_pkg::FRAME_BITS * max_div + 2000;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		// idle line and bus before the first write
		for (k = 0; k < 3; k++) begin
			@(negedge clk);
			// awready comes up on the first cycle after rst falls
			exp_awready = (k != 0);
			if (txd !== 1'b1 || wready !== 1'b0 || bvalid !== 1'b0 ||
				awready !== exp_awready) begin
				errors++;
				$display("FAIL t=%0t: after reset txd=%b awready=%b wready=%b bvalid=%b",
					$time, txd, awready, wready, bvalid);
			end
		end
		@(posedge clk);
		#1;
		foreach (stim_q[i]) begin
			ent = stim_q[i];
			if (ent.addr == 32'(uart_pkg::REG_DIVISOR)) begin
				// frames in flight keep the old period
				wait_line_idle();
				cur_div = expected_div(ent, cur_div);
			end
			if (ent.has_byte) begin
				exp_q.push_back(ent.byte_val);
			end
			hold = int'((lcg_next() >> 16) % 4);
			axil_write(ent, hold, resp);
			if (resp !== ent.resp) begin
				errors++;
				$display("FAIL t=%0t: entry %0d bresp %b, expected %b", $time, i, resp, ent.resp);
			end
		end
		wait_line_idle();
		// a spurious frame would start inside this window
		repeat (12 * cur_div) @(negedge clk);
		if (in_frame) begin
			errors++;
			$display("txd still sending a frame after the last expected byte");
		end
		report_counts();
		if (errors == 0 && dut.u_slave.u_axil_chk.fail_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

/* src.f */
hw/uart_pkg.sv
hw/uart_tx_if.sv
hw/uart_axil_slave.sv
hw/uart_tx_fifo.sv
hw/uart_tx_serializer.sv
hw/uart_top.sv
verif/uart_axil_assertions.sv
verif/tb_uart_top.sv
